// File: miss_buffer.f
mb_pkg.sv
mb_cam_if.sv
mb_cam.sv
mb_alloc.sv
mb_fill.sv
miss_buffer.sv
tb_miss_buffer.sv

// File: run_sim.sh
#!/bin/bash
# build and run the miss buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_miss_buffer \
  -f miss_buffer.f -o tb_miss_buffer > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_miss_buffer > sim.log 2>&1 || echo "simulation ended with an error"
cat sim.log
grep -qx "TEST PASS" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

// File: tb_miss_buffer.sv
// load miss buffer testbench
// drives misses and fills, and checks every miss result and fill
// address against a model of the entry valid bits and addresses
`timescale 1ns/10ps

module tb_miss_buffer;

  localparam int NUM_ENTRIES = 16;
  localparam int EW          = $clog2(NUM_ENTRIES);
  localparam int PA_W        = mb_pkg::PA_W;
  localparam int CLK_PERIOD  = 20;
  localparam int DIR_OPS     = 30;
  localparam int RAND_CYCLES = 600;
  // each operation drains well inside 10 cycles
  localparam int WD_CYCLES   = (DIR_OPS + RAND_CYCLES) * 10 + 200;

  logic             rclk = 1'b0;
  logic             rst_l;
  logic             miss_valid;
  logic [PA_W-1:0]  miss_pa;
  logic             miss_ready;
  logic             miss_done;
  logic [1:0]       miss_status;
  logic [EW-1:0]    miss_entry;
  logic             fill_valid;
  logic [EW-1:0]    fill_entry;
  logic             fill_done;
  logic [PA_W-1:0]  fill_pa;
  logic             mb_full;

  // model of the buffer
  logic [NUM_ENTRIES-1:0]  mdl_valid;
  logic [PA_W-1:0]         mdl_addr [NUM_ENTRIES];
  int                      fill_ok_at [NUM_ENTRIES];
  logic [31:0]             rng_state = 32'd95775;
  int                      cyc = 0;
  logic                    chk_on = 1'b0;
  logic                    dec_pend = 1'b0;
  int                      dec_cyc;
  logic [PA_W-1:0]         pend_pa;

  // expected results, read in order by the compare process
  logic [1:0]       q_st [$];
  int               q_ent [$];
  int               q_mdue [$];
  logic [PA_W-1:0]  q_pa [$];
  int               q_fdue [$];
  int               md_rd = 0;
  int               fd_rd = 0;
  logic             exp_md;
  logic             exp_fd;

  miss_buffer #(.NUM_ENTRIES(NUM_ENTRIES)) u_dut (.*);

  always #(CLK_PERIOD / 2) rclk = ~rclk;

  always @(posedge rclk) begin
    cyc <= cyc + 1;
  end

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // random tag and offset around a given set index
  function automatic logic [PA_W-1:0] make_pa(input logic [9:0] idx);
    logic [31:0] r;
    r = lcg_next();
    return {r[31:10], idx, r[9:2]};
  endfunction

  // merge, then conflict, then full, then lowest free entry
  function automatic void ref_miss(input logic [PA_W-1:0] pa, output logic [1:0] st,
                                   output int ent);
    int hit;
    int cfl;
    int fre;
    hit = -1;
    cfl = -1;
    fre = -1;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (!mdl_valid[i]) begin
        fre = i;
      end else if (mdl_addr[i][mb_pkg::KEY_HI:mb_pkg::KEY_LO] ==
                   pa[mb_pkg::KEY_HI:mb_pkg::KEY_LO]) begin
        hit = i;
      end else if (mdl_addr[i][mb_pkg::IDX_HI:mb_pkg::IDX_LO] ==
                   pa[mb_pkg::IDX_HI:mb_pkg::IDX_LO]) begin
        cfl = i;
      end
    end
    st  = mb_pkg::ST_ALLOC;
    ent = fre;
    if (hit >= 0) begin
      st  = mb_pkg::ST_MERGED;
      ent = hit;
    end else if (cfl >= 0) begin
      st  = mb_pkg::ST_CONFLICT;
      ent = cfl;
    end else if (fre < 0) begin
      st  = mb_pkg::ST_FULL;
      ent = 0;
    end
  endfunction

  // first valid entry from start on, optionally only ones safe to fill
  function automatic int pick_entry(input int start, input logic need_fill);
    int i;
    for (int k = 0; k < NUM_ENTRIES; k++) begin
      i = (start + k) % NUM_ENTRIES;
      if (mdl_valid[i] && (!need_fill || fill_ok_at[i] <= cyc)) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAIL time=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp);
      $display("TEST FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  // one cycle on, then resolve a miss whose decision edge comes next
  task next_cycle();
    logic [1:0] st;
    int         ent;
    @(posedge rclk);
    #2;
    miss_valid = 1'b0;
    fill_valid = 1'b0;
    if (dec_pend && cyc == dec_cyc) begin
      ref_miss(pend_pa, st, ent);
      q_st.push_back(st);
      q_ent.push_back(ent);
      q_mdue.push_back(cyc + 1);
      if (st == mb_pkg::ST_ALLOC) begin
        mdl_valid[ent]  = 1'b1;
        mdl_addr[ent]   = pend_pa;
        // the array write lands two edges after the decision
        fill_ok_at[ent] = cyc + 2;
      end
      dec_pend = 1'b0;
    end
  endtask

  task issue_miss(input logic [PA_W-1:0] pa);
    miss_valid = 1'b1;
    miss_pa    = pa;
    pend_pa    = pa;
    dec_pend   = 1'b1;
    dec_cyc    = cyc + 2;
  endtask

  task send_miss(input logic [PA_W-1:0] pa);
    next_cycle();
    while (!miss_ready) begin
      next_cycle();
    end
    issue_miss(pa);
  endtask

  task drive_fill(input int e);
    fill_valid    = 1'b1;
    fill_entry    = EW'(e);
    mdl_valid[e]  = 1'b0;
    q_pa.push_back(mdl_addr[e]);
    q_fdue.push_back(cyc + 3);
  endtask

  // wait until every expected result is seen and the allocator is idle
  task drain();
    next_cycle();
    while (dec_pend || md_rd != q_mdue.size() || fd_rd != q_fdue.size() || !miss_ready) begin
      next_cycle();
    end
    check_val("mb_full", 64'(mb_full), 64'(&mdl_valid));
  endtask

  always @(negedge rclk) begin
    if (chk_on) begin
      exp_md = (md_rd < q_mdue.size()) && (q_mdue[md_rd] == cyc);
      check_val("miss_done", 64'(miss_done), 64'(exp_md));
      if (exp_md) begin
        check_val("miss_status", 64'(miss_status), 64'(q_st[md_rd]));
        check_val("miss_entry", 64'(miss_entry), 64'(q_ent[md_rd]));
        md_rd = md_rd + 1;
      end
      exp_fd = (fd_rd < q_fdue.size()) && (q_fdue[fd_rd] == cyc);
      check_val("fill_done", 64'(fill_done), 64'(exp_fd));
      if (exp_fd) begin
        check_val("fill_pa", 64'(fill_pa), 64'(q_pa[fd_rd]));
        fd_rd = fd_rd + 1;
      end
    end
  end

  initial begin
    int              e;
    logic [31:0]     r;
    logic [PA_W-1:0] pa;
    rst_l      = 1'b0;
    miss_valid = 1'b0;
    miss_pa    = '0;
    fill_valid = 1'b0;
    fill_entry = '0;
    mdl_valid  = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      fill_ok_at[i] = 0;
    end
    repeat (8) next_cycle();
    rst_l  = 1'b1;
    chk_on = 1'b1;
    next_cycle();
    check_val("miss_ready", 64'(miss_ready), 64'd1);
    check_val("mb_full", 64'(mb_full), 64'd0);
    repeat (4) next_cycle();

    // distinct sets take the entries in order until the buffer is full
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      send_miss(make_pa(10'(i * 37 + 5)));
      drain();
    end
    check_val("mb_full", 64'(mb_full), 64'd1);
    send_miss(make_pa(10'd900));
    drain();

    // same line merges, same set under another tag conflicts
    pa      = mdl_addr[5];
    pa[7:0] = ~pa[7:0];
    send_miss(pa);
    pa         = mdl_addr[3];
    pa[PA_W-1] = ~pa[PA_W-1];
    send_miss(pa);
    drain();

    // single fill, then two back to back, then reuse of the freed entries
    next_cycle();
    drive_fill(2);
    drain();
    check_val("mb_full", 64'(mb_full), 64'd0);
    next_cycle();
    drive_fill(7);
    next_cycle();
    drive_fill(9);
    drain();
    send_miss(make_pa(10'd901));
    send_miss(make_pa(10'd902));
    drain();
    next_cycle();
    drive_fill(2);
    drain();

    // mixed traffic, misses and fills overlap
    repeat (RAND_CYCLES) begin
      next_cycle();
      r = lcg_next();
      if (miss_ready && r[16]) begin
        pa = make_pa({5'd0, r[25:21]});
        e  = pick_entry(int'(r[11:8]), 1'b0);
        if (e >= 0 && r[13:12] == 2'd0) begin
          pa[PA_W-1:mb_pkg::KEY_LO] = mdl_addr[e][PA_W-1:mb_pkg::KEY_LO];
        end else if (e >= 0 && r[13:12] == 2'd1) begin
          pa[mb_pkg::IDX_HI:mb_pkg::IDX_LO] = mdl_addr[e][mb_pkg::IDX_HI:mb_pkg::IDX_LO];
        end
        issue_miss(pa);
      end
      e = pick_entry(int'(r[27:20]), 1'b1);
      if (e >= 0 && r[31:30] == 2'd0) begin
        drive_fill(e);
      end
    end
    drain();

    $display("TEST PASS");
    $finish;
  end

  initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", WD_CYCLES);
    $display("TEST FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: miss_buffer.sv
// load miss buffer top level
// connects the miss allocator, the fill return path and the
// 40 bit CAM array that holds outstanding miss addresses
`timescale 1ns/10ps

module miss_buffer #(
  parameter  int NUM_ENTRIES = 16,
  localparam int EW          = $clog2(NUM_ENTRIES)
) (
  input  logic                     rclk,
  input  logic                     rst_l,
  input  logic                     miss_valid,
  input  logic [mb_pkg::PA_W-1:0]  miss_pa,
  output logic                     miss_ready,
  output logic                     miss_done,
  output logic [1:0]               miss_status,
  output logic [EW-1:0]            miss_entry,
  input  logic                     fill_valid,
  input  logic [EW-1:0]            fill_entry,
  output logic                     fill_done,
  output logic [mb_pkg::PA_W-1:0]  fill_pa,
  output logic                     mb_full
);

  // free notice from the fill path
  logic                     free_en;
  logic [NUM_ENTRIES-1:0]   free_wl;

  mb_cam_if #(.NUM_ENTRIES(NUM_ENTRIES)) cam_bus ();

  mb_cam #(.NUM_ENTRIES(NUM_ENTRIES)) u_cam (
    .rclk  (rclk),
    .rst_l (rst_l),
    .cam   (cam_bus.cam)
  );

  mb_alloc #(.NUM_ENTRIES(NUM_ENTRIES)) u_alloc (
    .rclk        (rclk),
    .rst_l       (rst_l),
    .miss_valid  (miss_valid),
    .miss_pa     (miss_pa),
    .miss_ready  (miss_ready),
    .miss_done   (miss_done),
    .miss_status (miss_status),
    .miss_entry  (miss_entry),
    .mb_full     (mb_full),
    .free_en     (free_en),
    .free_wl     (free_wl),
    .cam         (cam_bus.alloc)
  );

  mb_fill #(.NUM_ENTRIES(NUM_ENTRIES)) u_fill (
    .rclk       (rclk),
    .rst_l      (rst_l),
    .fill_valid (fill_valid),
    .fill_entry (fill_entry),
    .fill_done  (fill_done),
    .fill_pa    (fill_pa),
    .free_en    (free_en),
    .free_wl    (free_wl),
    .cam        (cam_bus.fill)
  );

endmodule

// File: mb_fill.sv
// miss buffer fill return path
// frees the returned entry, reads its address from the CAM and
// reports it two cycles after the fill is accepted
`timescale 1ns/10ps

module mb_fill #(
  parameter  int NUM_ENTRIES = 16,
  localparam int EW          = $clog2(NUM_ENTRIES)
) (
  input  logic                     rclk,
  input  logic                     rst_l,
  input  logic                     fill_valid,
  input  logic [EW-1:0]            fill_entry,
  output logic                     fill_done,
  output logic [mb_pkg::PA_W-1:0]  fill_pa,
  output logic                     free_en,
  output logic [NUM_ENTRIES-1:0]   free_wl,
  mb_cam_if.fill                   cam
);

  // stage 0 read in the array, stage 1 read data held
  logic [1:0]         pipe_v;
  mb_pkg::mb_entry_u  rd_q;

  // entry id to wordline
  assign free_wl = NUM_ENTRIES'(1) << fill_entry;
  assign free_en = fill_valid;

  // free and read go out on the same edge
  assign cam.ren   = fill_valid;
  assign cam.rd_wl = free_wl;

  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      pipe_v    <= '0;
      fill_done <= 1'b0;
    end else begin
      pipe_v    <= {pipe_v[0], fill_valid};
      fill_done <= pipe_v[1];
    end
  end

  // dout is valid the cycle after the read was registered
  always_ff @(posedge rclk) begin
    if (pipe_v[0]) begin
      rd_q.raw <= cam.dout;
    end
  end

  always_ff @(posedge rclk) begin
    if (pipe_v[1]) begin
      fill_pa <= {rd_q.f.tag, rd_q.f.idx, rd_q.f.off};
    end
  end

endmodule

// File: mb_alloc.sv
// miss buffer allocator
// tracks entry valid bits, looks up each new miss in the CAM and
// decides merge, conflict, full or allocation of the lowest free
// entry; an allocation writes the miss address into the array
`timescale 1ns/10ps

module mb_alloc #(
  parameter  int NUM_ENTRIES = 16,
  localparam int EW          = $clog2(NUM_ENTRIES)
) (
  input  logic                     rclk,
  input  logic                     rst_l,
  input  logic                     miss_valid,
  input  logic [mb_pkg::PA_W-1:0]  miss_pa,
  output logic                     miss_ready,
  output logic                     miss_done,
  output logic [1:0]               miss_status,
  output logic [EW-1:0]            miss_entry,
  output logic                     mb_full,
  input  logic                     free_en,
  input  logic [NUM_ENTRIES-1:0]   free_wl,
  mb_cam_if.alloc                  cam
);

  // miss sequence: lookup, wait for match, decide, write commit
  localparam logic [2:0] S_IDLE = 3'd0;
  localparam logic [2:0] S_LOOK = 3'd1;
  localparam logic [2:0] S_WAIT = 3'd2;
  localparam logic [2:0] S_WR   = 3'd3;
  localparam logic [2:0] S_CMT  = 3'd4;

  logic [2:0]               state;
  logic [NUM_ENTRIES-1:0]   valid;
  mb_pkg::mb_entry_u        pa_q;
  logic                     decide;
  logic [NUM_ENTRIES-1:0]   hit_vec;
  logic [NUM_ENTRIES-1:0]   idx_vec;
  logic [1:0]               st_n;
  logic [EW-1:0]            ent_n;
  logic [NUM_ENTRIES-1:0]   alloc_wl;
  logic [NUM_ENTRIES-1:0]   set_mask;
  logic [NUM_ENTRIES-1:0]   clr_mask;
  logic                     wen_q;
  logic [NUM_ENTRIES-1:0]   wr_wl_q;

  // lowest set bit of a vector
  function automatic logic [EW-1:0] first_set(input logic [NUM_ENTRIES-1:0] vec);
    logic [EW-1:0] pos;
    pos = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (vec[i]) begin
        pos = EW'(i);
      end
    end
    return pos;
  endfunction

  assign miss_ready = (state == S_IDLE);
  assign decide     = (state == S_WAIT);
  assign mb_full    = &valid;

  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE:  if (miss_valid) state <= S_LOOK;
        S_LOOK:  state <= S_WAIT;
        S_WAIT:  state <= S_WR;
        S_WR:    state <= S_CMT;
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge rclk) begin
    if (miss_valid && miss_ready) begin
      pa_q.raw <= miss_pa;
    end
  end

  // key is the line address, tag and index together
  assign cam.lookup_en = (state == S_LOOK);
  assign cam.key       = {pa_q.f.tag, pa_q.f.idx};

  // only live entries take part in the decision
  assign hit_vec = cam.match & valid;
  assign idx_vec = cam.match_idx & valid;

  always_comb begin
    if (|hit_vec) begin
      st_n  = mb_pkg::ST_MERGED;
      ent_n = first_set(hit_vec);
    end else if (|idx_vec) begin
      st_n  = mb_pkg::ST_CONFLICT;
      ent_n = first_set(idx_vec);
    end else if (&valid) begin
      st_n  = mb_pkg::ST_FULL;
      ent_n = '0;
    end else begin
      st_n  = mb_pkg::ST_ALLOC;
      ent_n = first_set(~valid);
    end
  end

  assign alloc_wl = NUM_ENTRIES'(1) << ent_n;
  assign set_mask = (decide && st_n == mb_pkg::ST_ALLOC) ? alloc_wl : '0;
  assign clr_mask = free_en ? free_wl : '0;

  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      valid     <= '0;
      miss_done <= 1'b0;
      wen_q     <= 1'b0;
    end else begin
      valid     <= (valid & ~clr_mask) | set_mask;
      miss_done <= decide;
      wen_q     <= |set_mask;
    end
  end

  always_ff @(posedge rclk) begin
    if (decide) begin
      miss_status <= st_n;
      miss_entry  <= ent_n;
      wr_wl_q     <= alloc_wl;
    end
  end

  assign cam.wen   = wen_q;
  assign cam.wr_wl = wr_wl_q;
  assign cam.din   = pa_q.raw;

  // a line is held by at most one live entry
  a_hit_onehot: assert property (
    @(posedge rclk) disable iff (!rst_l)
    decide |-> $onehot0(hit_vec)
  );

  a_free_valid: assert property (
    @(posedge rclk) disable iff (!rst_l)
    free_en |-> ((free_wl & valid) == free_wl)
  );

endmodule

// File: mb_cam.sv
// miss buffer CAM array
// NUM_ENTRIES x 40 bit words on one-hot wordlines, with registered
// write, read and lookup inputs; lookup compares the key against
// every word on the full line address and on the set index
`timescale 1ns/10ps

module mb_cam #(
  parameter int NUM_ENTRIES = 16
) (
  input  logic  rclk,
  input  logic  rst_l,
  mb_cam_if.cam cam
);

  // registered strobes
  logic                                   wen_d1;
  logic                                   ren_d1;
  logic                                   lookup_en_d1;

  // registered operands
  logic [NUM_ENTRIES-1:0]                 wr_wl_d1;
  logic [NUM_ENTRIES-1:0]                 rd_wl_d1;
  logic [mb_pkg::PA_W-1:0]                din_d1;
  logic [mb_pkg::KEY_HI:mb_pkg::KEY_LO]   key_d1;

  logic [mb_pkg::PA_W-1:0]                mem [NUM_ENTRIES];
  logic [mb_pkg::PA_W-1:0]                rd_word;
  logic [NUM_ENTRIES-1:0]                 match_p;
  logic [NUM_ENTRIES-1:0]                 match_idx_p;

  always_ff @(posedge rclk) begin
    if (!rst_l) begin
      wen_d1       <= 1'b0;
      ren_d1       <= 1'b0;
      lookup_en_d1 <= 1'b0;
    end else begin
      wen_d1       <= cam.wen;
      ren_d1       <= cam.ren;
      lookup_en_d1 <= cam.lookup_en;
    end
  end

  always_ff @(posedge rclk) begin
    wr_wl_d1 <= cam.wr_wl;
    rd_wl_d1 <= cam.rd_wl;
    din_d1   <= cam.din;
    key_d1   <= cam.key;
  end

  // write commits one edge after the strobe is registered
  always_ff @(posedge rclk) begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (wen_d1 && wr_wl_d1[i]) begin
        mem[i] <= din_d1;
      end
    end
  end

  // compare every word, full line address and set index
  always_comb begin
    match_p     = '0;
    match_idx_p = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      match_p[i]     = lookup_en_d1 &&
                       (mem[i][mb_pkg::KEY_HI:mb_pkg::KEY_LO] == key_d1);
      match_idx_p[i] = lookup_en_d1 &&
                       (mem[i][mb_pkg::IDX_HI:mb_pkg::IDX_LO] ==
                        key_d1[mb_pkg::IDX_HI:mb_pkg::IDX_LO]);
    end
  end

  assign cam.match     = match_p;
  assign cam.match_idx = match_idx_p;

  // and-or mux on the one-hot read wordline
  always_comb begin
    rd_word = '0;
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      rd_word = rd_word | ({mb_pkg::PA_W{rd_wl_d1[i]}} & mem[i]);
    end
  end

  assign cam.dout = ren_d1 ? rd_word : '0;

  // wordlines come from the allocator and fill path decoders
  a_wr_onehot: assert property (
    @(posedge rclk) disable iff (!rst_l)
    cam.wen |-> $onehot(cam.wr_wl)
  );

  a_rd_onehot: assert property (
    @(posedge rclk) disable iff (!rst_l)
    cam.ren |-> $onehot(cam.rd_wl)
  );

  // a fill must not return for an entry whose write is still in flight
  a_rd_wr_clash: assert property (
    @(posedge rclk) disable iff (!rst_l)
    (ren_d1 && wen_d1) |-> ((rd_wl_d1 & wr_wl_d1) == '0)
  );

  // miss sequencing keeps lookups clear of pending writes
  a_lookup_wr: assert property (
    @(posedge rclk) disable iff (!rst_l)
    !(lookup_en_d1 && wen_d1)
  );

endmodule

// File: mb_cam_if.sv
// miss buffer CAM port bundle
// write, lookup and read groups between the allocator, the fill
// path and the CAM array
`timescale 1ns/10ps

interface mb_cam_if #(
  parameter int NUM_ENTRIES = 16
);

  // write group
  logic                                   wen;
  logic [NUM_ENTRIES-1:0]                 wr_wl;
  logic [mb_pkg::PA_W-1:0]                din;

  // lookup group
  logic                                   lookup_en;
  logic [mb_pkg::KEY_HI:mb_pkg::KEY_LO]   key;
  logic [NUM_ENTRIES-1:0]                 match;
  logic [NUM_ENTRIES-1:0]                 match_idx;

  // read group
  logic                                   ren;
  logic [NUM_ENTRIES-1:0]                 rd_wl;
  logic [mb_pkg::PA_W-1:0]                dout;

  modport alloc (output wen, wr_wl, din, lookup_en, key,
                 input  match, match_idx);

  modport fill  (output ren, rd_wl,
                 input  dout);

  modport cam   (input  wen, wr_wl, din, lookup_en, key, ren, rd_wl,
                 output match, match_idx, dout);

endinterface

// File: mb_pkg.sv
// load miss buffer shared definitions
// address widths, CAM compare fields, miss status codes and the
// entry address word seen either raw or as tag, index and offset
package mb_pkg;

  // physical address width
  localparam int PA_W = 40;

  // line address used for a full match
  localparam int KEY_LO = 8;
  localparam int KEY_HI = 39;

  // set index used for a conflict match
  localparam int IDX_LO = 8;
  localparam int IDX_HI = 17;

  // miss status codes
  localparam logic [1:0] ST_ALLOC    = 2'd0;
  localparam logic [1:0] ST_MERGED   = 2'd1;
  localparam logic [1:0] ST_CONFLICT = 2'd2;
  localparam logic [1:0] ST_FULL     = 2'd3;

  // entry address word
  // tag 39:18, idx 17:8, off 7:0
  typedef union packed {
    logic [PA_W-1:0] raw;
    struct packed {
      logic [PA_W-IDX_HI-2:0]     tag;
      logic [IDX_HI-IDX_LO:0]     idx;
      logic [IDX_LO-1:0]          off;
    } f;
  } mb_entry_u;

endpackage
